//--- fetch_frontend_defs.svh
`ifndef FETCH_FRONTEND_DEFS_SVH
`define FETCH_FRONTEND_DEFS_SVH

// Address the core starts fetching from once reset is released
`define RESET_PC 32'h0000_0000

// Instruction memory size in 32-bit words
`define IMEM_DEPTH 256

// Word index width into the instruction memory, log2 of IMEM_DEPTH
`define IMEM_AW 8

// Number of branch target buffer entries
`define BTB_ENTRIES 16

// Index width into the target buffer, log2 of BTB_ENTRIES
`define BTB_IDX_W 4

// Width of the exception code carried with each fetched word
`define EXC_W 5

// MIPS cause code for an address error on load or fetch
`define EXC_ADEL_CODE 4

// Byte offset of the next sequential instruction
`define INST_BYTES 32'd4

`endif

//--- fetch_pkg.sv
`include "fetch_frontend_defs.svh"

package fetch_pkg;

    // Two-bit saturating counter of a target buffer entry
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,   // Value every counter takes at reset
        weak_t    = 2'b10,   // Lowest value that predicts taken
        strong_t  = 2'b11
    } ctr_e;

    // Class of a fetched word as seen by the pre-decoder
    typedef enum logic [1:0] {
        op_other  = 2'b00,
        op_j      = 2'b01,   // Opcode 000010
        op_jal    = 2'b10,   // Opcode 000011
        op_branch = 2'b11    // BEQ 000100 or BNE 000101
    } op_e;

    // Exception raised in the fetch stage
    typedef enum logic [`EXC_W-1:0] {
        exc_none = `EXC_W'(0),
        exc_adel = `EXC_W'(`EXC_ADEL_CODE)  // Fetch from a misaligned address
    } exc_e;

    // Raw MIPS opcodes the pre-decoder looks for
    localparam logic [5:0] OPC_J   = 6'b000010;
    localparam logic [5:0] OPC_JAL = 6'b000011;
    localparam logic [5:0] OPC_BEQ = 6'b000100;
    localparam logic [5:0] OPC_BNE = 6'b000101;

endpackage

//--- inst_mem.sv
`include "fetch_frontend_defs.svh"

module inst_mem (
    input  logic        clk,
    input  logic        mem_en,
    input  logic [31:0] mem_addr,
    output logic [31:0] mem_rdata,
    input  logic        prog_we,
    input  logic [31:0] prog_addr,
    input  logic [31:0] prog_wdata
);

    logic [31:0]          mem [`IMEM_DEPTH];
    logic [`IMEM_AW-1:0]  rd_idx;
    logic [`IMEM_AW-1:0]  wr_idx;

    // Byte addresses are turned into word indices, the low two bits are ignored
    assign rd_idx = mem_addr[`IMEM_AW+1:2];
    assign wr_idx = prog_addr[`IMEM_AW+1:2];

    // Program load port used before the core starts running
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[wr_idx] <= prog_wdata;
        end
    end

    // Registered read
    // The output keeps the last word while mem_en is low, which the fetch
    // stage relies on when decode stalls it
    always_ff @(posedge clk) begin
        if (mem_en) begin
            mem_rdata <= mem[rd_idx];
        end
    end

endmodule

//--- branch_predictor.sv
`include "fetch_frontend_defs.svh"

module branch_predictor (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] lookup_pc,
    output logic        pred_taken,
    output logic [31:0] pred_target,
    input  logic        br_valid,
    input  logic [31:0] br_pc,
    input  logic [31:0] br_target,
    input  logic        br_taken
);

    localparam int IDX_W = `BTB_IDX_W;
    localparam int TAG_W = 32 - IDX_W - 2;

    logic [`BTB_ENTRIES-1:0] btb_valid;
    logic [TAG_W-1:0]        btb_tag    [`BTB_ENTRIES];
    logic [31:0]             btb_target [`BTB_ENTRIES];
    fetch_pkg::ctr_e         btb_ctr    [`BTB_ENTRIES];

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic             lk_hit;
    fetch_pkg::ctr_e  lk_ctr;

    logic [IDX_W-1:0] up_idx;
    logic [TAG_W-1:0] up_tag;
    logic             up_hit;

    // Move a counter one step toward the resolved outcome, saturating at the ends
    function automatic fetch_pkg::ctr_e ctr_step(input fetch_pkg::ctr_e cur,
                                                 input logic taken);
        case (cur)
            fetch_pkg::strong_nt: ctr_step = taken ? fetch_pkg::weak_nt : fetch_pkg::strong_nt;
            fetch_pkg::weak_nt:   ctr_step = taken ? fetch_pkg::weak_t : fetch_pkg::strong_nt;
            fetch_pkg::weak_t:    ctr_step = taken ? fetch_pkg::strong_t : fetch_pkg::weak_nt;
            default:              ctr_step = taken ? fetch_pkg::strong_t : fetch_pkg::weak_t;
        endcase
    endfunction

    // Lookup side, indexed by the PC currently in the fetch stage
    assign lk_idx = lookup_pc[IDX_W+1:2];
    assign lk_tag = lookup_pc[31:IDX_W+2];
    assign lk_ctr = btb_ctr[lk_idx];
    assign lk_hit = btb_valid[lk_idx] && (btb_tag[lk_idx] == lk_tag);

    always_comb begin
        pred_taken  = lk_hit && (lk_ctr == fetch_pkg::weak_t ||
                                 lk_ctr == fetch_pkg::strong_t);
        pred_target = btb_target[lk_idx];
    end

    // Update side, driven by resolved branches coming back from decode
    assign up_idx = br_pc[IDX_W+1:2];
    assign up_tag = br_pc[31:IDX_W+2];
    assign up_hit = btb_valid[up_idx] && (btb_tag[up_idx] == up_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            btb_valid <= '0;
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                btb_ctr[i] <= fetch_pkg::weak_nt;
            end
        end else if (br_valid) begin
            if (up_hit) begin
                btb_ctr[up_idx] <= ctr_step(btb_ctr[up_idx], br_taken);
            end else if (br_taken) begin
                // A fresh entry starts weakly not taken, so it takes a second
                // taken outcome before the entry predicts
                btb_valid[up_idx] <= 1'b1;
                btb_ctr[up_idx]   <= fetch_pkg::weak_nt;
            end
        end
    end

    // Tag and target only change when a taken branch installs or refreshes them
    always_ff @(posedge clk) begin
        if (br_valid && br_taken) begin
            btb_tag[up_idx]    <= up_tag;
            btb_target[up_idx] <= br_target;
        end
    end

endmodule

//--- pc_gen_stage.sv
`include "fetch_frontend_defs.svh"

module pc_gen_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        fs_allowin,
    output logic        ps_valid,
    output logic [31:0] ps_pc,
    output logic        mem_en,
    output logic [31:0] mem_addr,
    input  logic        pred_redirect,
    input  logic [31:0] pred_target,
    input  logic        flush,
    input  logic [31:0] flush_pc
);

    logic        pc_live;   // Low only until the first edge after reset
    logic [31:0] pc_r;
    logic        cancel;

    // A new address arrives next cycle so the one on offer now is dropped
    assign cancel   = flush || pred_redirect;
    assign ps_valid = pc_live && !cancel;
    assign ps_pc    = pc_r;

    // The read is issued on the same cycle the address moves into fs
    assign mem_en   = ps_valid && fs_allowin;
    assign mem_addr = pc_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_live <= 1'b0;
            pc_r    <= `RESET_PC;
        end else begin
            pc_live <= 1'b1;
            if (flush) begin
                pc_r <= flush_pc;
            end else if (pred_redirect) begin
                pc_r <= pred_target;   // Jump or predicted branch target
            end else if (mem_en) begin
                pc_r <= pc_r + `INST_BYTES;
            end
        end
    end

endmodule

//--- if_stage.sv
module if_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             ps_valid,
    input  logic [31:0]      ps_pc,
    output logic             fs_allowin,
    input  logic [31:0]      mem_rdata,
    input  logic             ds_allowin,
    output logic             fs_to_ds_valid,
    output logic [31:0]      fs_pc,
    output logic [31:0]      fs_inst,
    output fetch_pkg::exc_e  fs_exc,
    input  logic             pred_taken,
    input  logic [31:0]      pred_target,
    output logic             pred_redirect,
    output logic [31:0]      redirect_target,
    input  logic             flush
);

    logic           fs_valid;
    logic           fs_first;     // High on the first cycle an item sits in fs
    logic           fs_accept;
    logic [31:0]    inst_buf;
    logic [31:0]    raw_inst;
    logic           fs_misaligned;
    fetch_pkg::op_e fs_op;
    logic           is_jump;
    logic [31:0]    jump_target;

    // Sort the fetched word into the classes the redirect logic cares about
    function automatic fetch_pkg::op_e predecode(input logic [5:0] opcode);
        case (opcode)
            fetch_pkg::OPC_J:   predecode = fetch_pkg::op_j;
            fetch_pkg::OPC_JAL: predecode = fetch_pkg::op_jal;
            fetch_pkg::OPC_BEQ,
            fetch_pkg::OPC_BNE: predecode = fetch_pkg::op_branch;
            default:            predecode = fetch_pkg::op_other;
        endcase
    endfunction

    // fs empties when decode takes its item, so one new item per cycle
    assign fs_allowin     = !fs_valid || ds_allowin;
    assign fs_accept      = ps_valid && fs_allowin;   // ps_valid is already cut on redirect
    assign fs_to_ds_valid = fs_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
            fs_first <= 1'b0;
        end else if (flush) begin
            fs_valid <= 1'b0;   // Drops the held item and any pending prediction
            fs_first <= 1'b0;
        end else begin
            if (fs_allowin) begin
                fs_valid <= ps_valid;
            end
            fs_first <= fs_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_accept) begin
            fs_pc <= ps_pc;
        end
        if (fs_first) begin
            inst_buf <= mem_rdata;   // Keep the word in case decode stalls us
        end
    end

    // Memory data is only fresh on the first cycle, after that use the copy
    assign raw_inst = fs_first ? mem_rdata : inst_buf;

    assign fs_misaligned = (fs_pc[1:0] != 2'b00);
    assign fs_inst       = fs_misaligned ? 32'h0 : raw_inst;
    assign fs_exc        = fs_misaligned ? fetch_pkg::exc_adel : fetch_pkg::exc_none;

    // Pre-decode for early redirects
    assign fs_op       = predecode(raw_inst[31:26]);
    assign is_jump     = (fs_op == fetch_pkg::op_j) || (fs_op == fetch_pkg::op_jal);
    assign jump_target = {fs_pc[31:28], raw_inst[25:0], 2'b00};

    // One-shot redirect, raised only on the first cycle the item is in fs
    always_comb begin
        pred_redirect = fs_valid && fs_first && !fs_misaligned && !flush &&
                        (is_jump || (fs_op == fetch_pkg::op_branch && pred_taken));
        redirect_target = is_jump ? jump_target : pred_target;
    end

endmodule

//--- fetch_frontend.sv
module fetch_frontend (
    input  logic             clk,
    input  logic             reset,
    input  logic             prog_we,
    input  logic [31:0]      prog_addr,
    input  logic [31:0]      prog_wdata,
    input  logic             ds_allowin,
    output logic             fs_to_ds_valid,
    output logic [31:0]      fs_pc,
    output logic [31:0]      fs_inst,
    output fetch_pkg::exc_e  fs_exc,
    input  logic             br_valid,
    input  logic             br_taken,
    input  logic [31:0]      br_pc,
    input  logic [31:0]      br_target,
    input  logic             flush,
    input  logic [31:0]      flush_pc
);

    logic        ps_valid;
    logic [31:0] ps_pc;
    logic        fs_allowin;
    logic        mem_en;
    logic [31:0] mem_addr;
    logic [31:0] mem_rdata;
    logic        pred_taken;       // Target buffer says the branch in fs is taken
    logic [31:0] btb_target;
    logic        pred_redirect;
    logic [31:0] redirect_target;  // Jump or predicted branch target for ps

    pc_gen_stage pc_gen0 (
        .clk           (clk),
        .reset         (reset),
        .fs_allowin    (fs_allowin),
        .ps_valid      (ps_valid),
        .ps_pc         (ps_pc),
        .mem_en        (mem_en),
        .mem_addr      (mem_addr),
        .pred_redirect (pred_redirect),
        .pred_target   (redirect_target),
        .flush         (flush),
        .flush_pc      (flush_pc)
    );

    inst_mem imem0 (
        .clk        (clk),
        .mem_en     (mem_en),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_wdata (prog_wdata)
    );

    if_stage if_stage0 (
        .clk             (clk),
        .reset           (reset),
        .ps_valid        (ps_valid),
        .ps_pc           (ps_pc),
        .fs_allowin      (fs_allowin),
        .mem_rdata       (mem_rdata),
        .ds_allowin      (ds_allowin),
        .fs_to_ds_valid  (fs_to_ds_valid),
        .fs_pc           (fs_pc),
        .fs_inst         (fs_inst),
        .fs_exc          (fs_exc),
        .pred_taken      (pred_taken),
        .pred_target     (btb_target),
        .pred_redirect   (pred_redirect),
        .redirect_target (redirect_target),
        .flush           (flush)
    );

    // Lookup follows the PC held in fs, updates come straight from decode
    branch_predictor bp0 (
        .clk         (clk),
        .reset       (reset),
        .lookup_pc   (fs_pc),
        .pred_taken  (pred_taken),
        .pred_target (btb_target),
        .br_valid    (br_valid),
        .br_pc       (br_pc),
        .br_target   (br_target),
        .br_taken    (br_taken)
    );

endmodule

//--- tb_fetch_frontend.sv
`include "fetch_frontend_defs.svh"

module tb_fetch_frontend;

    logic            clk;
    logic            reset;
    logic            prog_we;
    logic [31:0]     prog_addr;
    logic [31:0]     prog_wdata;
    logic            ds_allowin;
    logic            fs_to_ds_valid;
    logic [31:0]     fs_pc;
    logic [31:0]     fs_inst;
    fetch_pkg::exc_e fs_exc;
    logic            br_valid;
    logic            br_taken;
    logic [31:0]     br_pc;
    logic [31:0]     br_target;
    logic            flush;
    logic [31:0]     flush_pc;

    logic [31:0] prog_img [`IMEM_DEPTH];   // Program image that the reference model also reads

    // Reference copy of the predictor with counters 0..3 where 2 and up predict taken
    logic        m_valid [`BTB_ENTRIES];
    logic [31:0] m_pc    [`BTB_ENTRIES];
    logic [31:0] m_tgt   [`BTB_ENTRIES];
    int          m_ctr   [`BTB_ENTRIES];

    logic [31:0] exp_pc[$];
    logic [31:0] exp_inst[$];
    logic [31:0] exp_exc[$];
    logic [31:0] got_pc[$];
    logic [31:0] got_inst[$];
    logic [31:0] got_exc[$];

    int          errors;
    int          tests_run;
    bit          timed_out;

    fetch_frontend dut0 (
        .clk            (clk),
        .reset          (reset),
        .prog_we        (prog_we),
        .prog_addr      (prog_addr),
        .prog_wdata     (prog_wdata),
        .ds_allowin     (ds_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .fs_exc         (fs_exc),
        .br_valid       (br_valid),
        .br_taken       (br_taken),
        .br_pc          (br_pc),
        .br_target      (br_target),
        .flush          (flush),
        .flush_pc       (flush_pc)
    );

    always #2 clk = ~clk;

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // ADDIU whose immediate is the word's own byte address
    function automatic logic [31:0] fill_word(input int idx);
        return 32'h2400_0000 | (idx << 2);
    endfunction

    // Where fetch goes after pc when it follows the jump and prediction rules
    function automatic logic [31:0] next_pc_of(input logic [31:0] pc);
        logic [31:0]           w;
        logic [5:0]            opc;
        logic [`BTB_IDX_W-1:0] idx;
        w   = prog_img[pc[`IMEM_AW+1:2]];
        opc = w[31:26];
        idx = pc[`BTB_IDX_W+1:2];
        if (pc[1:0] != 2'b00) begin
            return pc + 32'd4;   // No redirect from a faulting fetch
        end
        if (opc == 6'b000010 || opc == 6'b000011) begin
            return {pc[31:28], w[25:0], 2'b00};
        end
        if ((opc == 6'b000100 || opc == 6'b000101) && m_valid[idx] && m_pc[idx] == pc &&
            m_ctr[idx] >= 2) begin
            return m_tgt[idx];
        end
        return pc + 32'd4;
    endfunction

    task automatic build_expected(input logic [31:0] start, input int n);
        logic [31:0] pc;
        exp_pc.delete();
        exp_inst.delete();
        exp_exc.delete();
        pc = start;
        for (int i = 0; i < n; i++) begin
            exp_pc.push_back(pc);
            if (pc[1:0] != 2'b00) begin
                exp_inst.push_back(32'h0);
                exp_exc.push_back(32'(fetch_pkg::exc_adel));
            end else begin
                exp_inst.push_back(prog_img[pc[`IMEM_AW+1:2]]);
                exp_exc.push_back(32'(fetch_pkg::exc_none));
            end
            pc = next_pc_of(pc);
        end
    endtask

    // Writes the whole image while reset is held, then releases reset
    task automatic load_program();
        reset      = 1'b1;
        ds_allowin = 1'b0;
        flush      = 1'b0;
        br_valid   = 1'b0;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            @(posedge clk);
            #1;
            prog_we    = 1'b1;
            prog_addr  = i << 2;
            prog_wdata = prog_img[i];
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_ctr[i]   = 1;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic resolve_branch(input logic [31:0] pc, input logic taken,
                                  input logic [31:0] tgt);
        logic [`BTB_IDX_W-1:0] idx;
        idx = pc[`BTB_IDX_W+1:2];
        @(posedge clk);
        #1;
        br_valid  = 1'b1;
        br_pc     = pc;
        br_taken  = taken;
        br_target = tgt;
        @(posedge clk);
        #1;
        br_valid = 1'b0;
        if (m_valid[idx] && m_pc[idx] == pc) begin
            if (taken && m_ctr[idx] < 3) begin
                m_ctr[idx]++;
            end else if (!taken && m_ctr[idx] > 0) begin
                m_ctr[idx]--;
            end
        end else if (taken) begin
            m_valid[idx] = 1'b1;
            m_ctr[idx]   = 1;   // A new entry starts weakly not taken
        end
        if (taken) begin
            m_pc[idx]  = pc;
            m_tgt[idx] = tgt;
        end
    endtask

    task automatic do_flush(input logic [31:0] pc);
        @(posedge clk);
        #1;
        flush    = 1'b1;
        flush_pc = pc;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    // Takes n items from the decode side and checks that stalled outputs hold
    task automatic collect_outputs(input int n, input bit stall);
        int          cycles;
        bit          held;
        logic [31:0] h_pc;
        logic [31:0] h_inst;
        logic [31:0] h_exc;
        got_pc.delete();
        got_inst.delete();
        got_exc.delete();
        cycles = 0;
        held   = 1'b0;
        while (got_pc.size() < n && !timed_out) begin
            @(posedge clk);
            #1;
            ds_allowin = stall ? 1'($urandom % 2) : 1'b1;
            @(negedge clk);
            if (held) begin
                check_eq("fs_to_ds_valid (held)", 32'(fs_to_ds_valid), 32'd1);
                check_eq("fs_pc (held)", fs_pc, h_pc);
                check_eq("fs_inst (held)", fs_inst, h_inst);
                check_eq("fs_exc (held)", 32'(fs_exc), h_exc);
            end
            held   = fs_to_ds_valid && !ds_allowin;
            h_pc   = fs_pc;
            h_inst = fs_inst;
            h_exc  = 32'(fs_exc);
            if (fs_to_ds_valid && ds_allowin) begin
                got_pc.push_back(fs_pc);
                got_inst.push_back(fs_inst);
                got_exc.push_back(32'(fs_exc));
            end
            cycles++;
            if (cycles > n * 16 + 40) begin
                $display("Timeout: only %0d of %0d outputs came out of the DUT",
                         got_pc.size(), n);
                errors++;
                timed_out = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        ds_allowin = 1'b0;
    endtask

    task automatic compare_outputs();
        for (int i = 0; i < exp_pc.size() && i < got_pc.size(); i++) begin
            check_eq("fs_pc", got_pc[i], exp_pc[i]);
            check_eq("fs_inst", got_inst[i], exp_inst[i]);
            check_eq("fs_exc", got_exc[i], exp_exc[i]);
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        $display("Test %s finished with %0d errors", name, errors - err0);
    endtask

    task automatic straight_line_fetch();
        int err0;
        int cyc;
        err0 = errors;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            prog_img[i] = fill_word(i);
        end
        load_program();
        cyc = 0;
        while (!fs_to_ds_valid && !timed_out) begin
            @(posedge clk);
            #1;
            cyc++;
            if (cyc >= 20) begin
                $display("Timeout: no output appeared after reset was released");
                errors++;
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            check_eq("first output latency", cyc, 2);
            build_expected(`RESET_PC, 12);
            collect_outputs(12, 1'b0);
            compare_outputs();
        end
        end_test("straight_line", err0);
    endtask

    task automatic jump_redirect();
        int err0;
        err0 = errors;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            prog_img[i] = fill_word(i);
        end
        prog_img[1]  = 32'h0800_0010;   // J 0x40
        prog_img[18] = 32'h0C00_0020;   // JAL 0x80 at 0x48
        load_program();
        build_expected(`RESET_PC, 10);
        collect_outputs(10, 1'b0);
        compare_outputs();
        end_test("jumps", err0);
    endtask

    task automatic branch_training();
        int err0;
        err0 = errors;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            prog_img[i] = fill_word(i);
        end
        prog_img[2] = 32'h1000_0005;   // BEQ at 0x08
        load_program();
        build_expected(`RESET_PC, 6);   // Not trained yet so the branch falls through
        collect_outputs(6, 1'b0);
        compare_outputs();
        resolve_branch(32'h08, 1'b1, 32'h60);
        resolve_branch(32'h08, 1'b1, 32'h60);
        do_flush(`RESET_PC);
        build_expected(`RESET_PC, 6);
        collect_outputs(6, 1'b0);
        compare_outputs();
        resolve_branch(32'h08, 1'b0, 32'h0);
        resolve_branch(32'h08, 1'b0, 32'h0);
        do_flush(`RESET_PC);
        build_expected(`RESET_PC, 6);
        collect_outputs(6, 1'b0);
        compare_outputs();
        end_test("branches", err0);
    endtask

    task automatic stall_sequence();
        int err0;
        err0 = errors;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            prog_img[i] = fill_word(i);
        end
        prog_img[1]  = 32'h0800_0010;   // J 0x40
        prog_img[18] = 32'h0C00_0020;   // JAL 0x80
        prog_img[33] = 32'h1400_0003;   // BNE at 0x84 that is trained taken to 0x10
        load_program();
        resolve_branch(32'h84, 1'b1, 32'h10);
        resolve_branch(32'h84, 1'b1, 32'h10);
        build_expected(`RESET_PC, 24);
        collect_outputs(24, 1'b1);
        compare_outputs();
        end_test("backpressure", err0);
    endtask

    task automatic flush_redirect();
        int err0;
        err0 = errors;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            prog_img[i] = fill_word(i);
        end
        load_program();
        do_flush(32'h30);
        build_expected(32'h30, 4);
        collect_outputs(4, 1'b0);
        compare_outputs();
        do_flush(32'h22);   // A misaligned address makes the fetch fault
        build_expected(32'h22, 2);
        collect_outputs(2, 1'b0);
        compare_outputs();
        end_test("flush", err0);
    endtask

    initial begin
        void'($urandom(32'h9321_1d12));
        errors     = 0;
        tests_run  = 0;
        timed_out  = 1'b0;
        clk        = 1'b0;
        reset      = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = 32'h0;
        prog_wdata = 32'h0;
        ds_allowin = 1'b0;
        br_valid   = 1'b0;
        br_taken   = 1'b0;
        br_pc      = 32'h0;
        br_target  = 32'h0;
        flush      = 1'b0;
        flush_pc   = 32'h0;
        straight_line_fetch();
        if (!timed_out) jump_redirect();
        if (!timed_out) branch_training();
        if (!timed_out) stall_sequence();
        if (!timed_out) flush_redirect();
        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- fetch_frontend.f
+incdir+.
fetch_pkg.sv
inst_mem.sv
branch_predictor.sv
pc_gen_stage.sv
if_stage.sv
fetch_frontend.sv
tb_fetch_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f fetch_frontend.f --top-module tb_fetch_frontend \
    -Mdir obj_dir -o sim_fetch_frontend \
    && ./obj_dir/sim_fetch_frontend > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -q "^Simulation finished: PASS$" sim.log \
    && echo "Result: passed" \
    || { echo "Result: failed"; exit 1; }
